// ==== list.f ====
+incdir+include
hw/fixed_point_pkg.sv
hw/render_pkg.sv
hw/escape_if.sv
hw/escape_engine.sv
hw/color_mapper.sv
hw/pixel_scanner.sv
hw/mandel_render_top.sv
testbench/tb_mandel_render.sv

// ==== Makefile ====
TOP := tb_mandel_render

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall +incdir+include \
		hw/fixed_point_pkg.sv hw/render_pkg.sv hw/escape_if.sv \
		hw/escape_engine.sv hw/color_mapper.sv hw/pixel_scanner.sv \
		hw/mandel_render_top.sv --top-module mandel_render_top
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_mandel_render.sv ====
`include "mandel_params.svh"

module tb_mandel_render import fixed_point_pkg::*, render_pkg::*; ();

	localparam int H = 16;
	localparam int V = 12;
	localparam int NPIX = H * V;

	// Cycle budget for any single wait
	localparam int WAIT_LIMIT = 100000;

	// Top-left corner -2.0 + 1.2i in 4.23
	localparam fix_t RE_MIN  = fix_t'(-2 * (1 << `MANDEL_FRAC_W));
	localparam fix_t IM_MAX  = fix_t'(10066330);
	localparam fix_t RE_STEP = fix_t'(1572864);
	localparam fix_t IM_STEP = fix_t'(1677722);

	// x = 10, y = 6 lands on about -0.125 + 0i
	localparam int INSIDE_ADDR = 6 * H + 10;

	// Where the second frame gets cut short
	localparam int MID_ADDR = 70;

	logic      clk;
	logic      reset;
	fix_t      re_min;
	fix_t      im_max;
	fix_t      re_step;
	fix_t      im_step;
	iter_t     max_iter;
	logic      fb_we;
	pix_addr_t fb_addr;
	rgb332_t   fb_color;
	logic      frame_done;

	int        errors;
	int        timeouts;
	logic      timed_out;

	// Scoreboard state
	pix_addr_t exp_addr;
	int        write_count;
	logic      after_reset;
	rgb332_t   expected_color [NPIX];

	mandel_render_top #(
		.H_PIXELS (H),
		.V_PIXELS (V)
	) dut_i (
		.clk        (clk),
		.reset      (reset),
		.re_min     (re_min),
		.im_max     (im_max),
		.re_step    (re_step),
		.im_step    (im_step),
		.max_iter   (max_iter),
		.fb_we      (fb_we),
		.fb_addr    (fb_addr),
		.fb_color   (fb_color),
		.frame_done (frame_done)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ==========================================================================
	// Reference model
	// ==========================================================================

	// Iterations of z <- z^2 + c until the limit or |z|^2 above 4
	function automatic iter_t escape_count(input fix_t c_re, input fix_t c_im,
			input iter_t limit);
		fix_t     zr;
		fix_t     zi;
		fix_t     zr_sq;
		fix_t     zi_sq;
		fix_t     zr_zi;
		fix_mag_t mag;
		iter_t    n;
		logic     out;
		zr  = '0;
		zi  = '0;
		n   = '0;
		out = 1'b0;
		while (n != limit && !out) begin
			zr_sq = fix_mul(zr, zr);
			zi_sq = fix_mul(zi, zi);
			zr_zi = fix_mul(zr, zi);
			mag   = fix_mag_t'(zr_sq) + fix_mag_t'(zi_sq);
			if (mag > fix_mag_t'(`MANDEL_ESCAPE)) begin
				out = 1'b1;
			end else begin
				zr = zr_sq - zi_sq + c_re;
				zi = (zr_zi <<< 1) + c_im;
				n  = n + 1'b1;
			end
		end
		return n;
	endfunction

	// First k in 1..8 with n >= limit >> k and black inside the set
	function automatic rgb332_t ladder_color(input iter_t n, input iter_t limit);
		int idx;
		idx = `MANDEL_PALETTE_N - 1;
		if (n == limit) begin
			idx = 0;
		end else begin
			for (int k = 1; k <= 8; k++) begin
				if (idx == `MANDEL_PALETTE_N - 1 && n >= (limit >> k))
					idx = k;
			end
		end
		return PALETTE[idx];
	endfunction

	// Colour of every pixel for one limit
	task automatic build_expected(input iter_t limit);
		fix_t c_re;
		fix_t c_im;
		for (int y = 0; y < V; y++) begin
			for (int x = 0; x < H; x++) begin
				c_re = RE_MIN + fix_t'(x * RE_STEP);
				c_im = IM_MAX - fix_t'(y * IM_STEP);
				expected_color[y * H + x] = ladder_color(escape_count(c_re, c_im, limit),
					limit);
			end
		end
	endtask

	// ==========================================================================
	// Stimulus helpers
	// ==========================================================================

	// New limit, then reset held for two cycles
	task automatic start_frame(input iter_t limit);
		max_iter <= limit;
		build_expected(limit);
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic wait_frame_done(output logic late);
		int n;
		n    = 0;
		late = 1'b0;
		@(posedge clk);
		while (!frame_done && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (!frame_done) begin
			$display("Timeout: frame_done did not rise within %0d cycles", WAIT_LIMIT);
			timeouts++;
			late = 1'b1;
		end
	endtask

	task automatic wait_write_to(input int target, output logic late);
		int n;
		n    = 0;
		late = 1'b0;
		@(posedge clk);
		while (!(fb_we && fb_addr == pix_addr_t'(target)) && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (!(fb_we && fb_addr == pix_addr_t'(target))) begin
			$display("Timeout: no write to address %0d within %0d cycles", target,
				WAIT_LIMIT);
			timeouts++;
			late = 1'b1;
		end
	endtask

	// Next address, writes so far, first write after a reset
	always @(posedge clk) begin
		if (reset) begin
			exp_addr    <= '0;
			write_count <= 0;
			after_reset <= 1'b1;
		end else if (fb_we) begin
			exp_addr    <= exp_addr + 1'b1;
			write_count <= write_count + 1;
			after_reset <= 1'b0;
		end
	end

	// ==========================================================================
	// Checks
	// ==========================================================================

	a_reset_we: assert property (@(posedge clk) reset |=> !fb_we)
		else begin
			errors++;
			$display("FAILED t=%0t fb_we got %b expected 0", $time, $sampled(fb_we));
		end

	a_reset_done: assert property (@(posedge clk) reset |=> !frame_done)
		else begin
			errors++;
			$display("FAILED t=%0t frame_done got %b expected 0", $time,
				$sampled(frame_done));
		end

	// Still quiet two cycles after release
	a_release: assert property (@(posedge clk) $fell(reset) |=> (!fb_we && !frame_done))
		else begin
			errors++;
			$display("FAILED t=%0t fb_we/frame_done got %b/%b expected 0/0", $time,
				$sampled(fb_we), $sampled(frame_done));
		end

	a_addr_order: assert property (@(posedge clk) disable iff (reset)
		fb_we |-> fb_addr == exp_addr)
		else begin
			errors++;
			$display("FAILED t=%0t fb_addr got %0d expected %0d", $time,
				$sampled(fb_addr), $sampled(exp_addr));
		end

	a_addr_first: assert property (@(posedge clk) disable iff (reset)
		(fb_we && after_reset) |-> fb_addr == '0)
		else begin
			errors++;
			$display("FAILED t=%0t fb_addr got %0d expected 0", $time, $sampled(fb_addr));
		end

	a_color: assert property (@(posedge clk) disable iff (reset)
		(fb_we && fb_addr < NPIX) |-> fb_color == expected_color[fb_addr])
		else begin
			errors++;
			$display("FAILED t=%0t fb_color at %0d got %h expected %h", $time,
				$sampled(fb_addr), $sampled(fb_color), expected_color[$sampled(fb_addr)]);
		end

	// Point inside the set must come out black
	a_inside_black: assert property (@(posedge clk) disable iff (reset)
		(fb_we && fb_addr == INSIDE_ADDR) |-> fb_color == PALETTE[0])
		else begin
			errors++;
			$display("FAILED t=%0t fb_color got %h expected %h", $time,
				$sampled(fb_color), PALETTE[0]);
		end

	a_done_after_last: assert property (@(posedge clk) disable iff (reset)
		(fb_we && fb_addr == NPIX - 1) |=> frame_done)
		else begin
			errors++;
			$display("FAILED t=%0t frame_done got %b expected 1", $time,
				$sampled(frame_done));
		end

	a_done_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(frame_done) |-> $past(fb_we))
		else begin
			errors++;
			$display("frame_done rose at t=%0t without a write in the cycle before", $time);
		end

	a_write_total: assert property (@(posedge clk) disable iff (reset)
		$rose(frame_done) |-> write_count == NPIX)
		else begin
			errors++;
			$display("FAILED t=%0t write_count got %0d expected %0d", $time,
				$sampled(write_count), NPIX);
		end

	a_done_hold: assert property (@(posedge clk) disable iff (reset)
		frame_done |=> (frame_done && !fb_we))
		else begin
			errors++;
			$display("frame_done dropped or a write followed it at t=%0t", $time);
		end

	// ==========================================================================
	// Main sequence
	// ==========================================================================

	initial begin
		errors    = 0;
		timeouts  = 0;
		timed_out = 1'b0;
		re_min    <= RE_MIN;
		im_max    <= IM_MAX;
		re_step   <= RE_STEP;
		im_step   <= IM_STEP;
		start_frame(16'd40);
		wait_frame_done(timed_out);
		if (!timed_out) begin
			// Let frame_done sit, then cut the next frame short
			repeat (8) @(posedge clk);
			start_frame(16'd200);
			wait_write_to(MID_ADDR, timed_out);
		end
		if (!timed_out) begin
			start_frame(16'd200);
			wait_frame_done(timed_out);
		end
		repeat (4) @(posedge clk);
		$display("Run complete: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== hw/mandel_render_top.sv ====
`include "mandel_params.svh"

module mandel_render_top import fixed_point_pkg::*, render_pkg::*; #(
	parameter int H_PIXELS = `MANDEL_H_DEFAULT,
	parameter int V_PIXELS = `MANDEL_V_DEFAULT
) (
	input  logic      clk,
	input  logic      reset,
	input  fix_t      re_min,
	input  fix_t      im_max,
	input  fix_t      re_step,
	input  fix_t      im_step,
	input  iter_t     max_iter,
	output logic      fb_we,
	output pix_addr_t fb_addr,
	output rgb332_t   fb_color,
	output logic      frame_done
);

	// Scanner, engine and mapper share one bundle
	escape_if esc_i ();

	// Address of the pixel now in the engine
	pix_addr_t pix_addr;

	pixel_scanner #(
		.H_PIXELS (H_PIXELS),
		.V_PIXELS (V_PIXELS)
	) scanner_i (
		.clk        (clk),
		.reset      (reset),
		.re_min     (re_min),
		.im_max     (im_max),
		.re_step    (re_step),
		.im_step    (im_step),
		.max_iter   (max_iter),
		.esc        (esc_i.scanner),
		.pix_addr   (pix_addr),
		.frame_done (frame_done)
	);

	escape_engine engine_i (
		.clk   (clk),
		.reset (reset),
		.esc   (esc_i.engine)
	);

	color_mapper mapper_i (
		.clk      (clk),
		.reset    (reset),
		.esc      (esc_i.mapper),
		.pix_addr (pix_addr),
		.fb_we    (fb_we),
		.fb_addr  (fb_addr),
		.fb_color (fb_color)
	);

endmodule

// ==== hw/pixel_scanner.sv ====
`include "mandel_params.svh"

module pixel_scanner import fixed_point_pkg::*, render_pkg::*; #(
	parameter int H_PIXELS = `MANDEL_H_DEFAULT,
	parameter int V_PIXELS = `MANDEL_V_DEFAULT
) (
	input  logic       clk,
	input  logic       reset,
	input  fix_t       re_min,
	input  fix_t       im_max,
	input  fix_t       re_step,
	input  fix_t       im_step,
	input  iter_t      max_iter,
	escape_if.scanner  esc,
	output pix_addr_t  pix_addr,
	output logic       frame_done
);

	// Counter widths
	localparam int X_W = (H_PIXELS > 1) ? $clog2(H_PIXELS) : 1;
	localparam int Y_W = (V_PIXELS > 1) ? $clog2(V_PIXELS) : 1;

	scan_state_t state;

	// One-cycle start strobe
	logic start_q;

	// Raster position of the pixel in the engine
	logic [X_W-1:0] x;
	logic [Y_W-1:0] y;
	pix_addr_t      addr;

	// c for that pixel
	fix_t  c_re;
	fix_t  c_im;

	// Limit held for the whole frame
	iter_t max_q;

	logic last_col;
	logic last_pixel;

	assign last_col   = (x == X_W'(H_PIXELS - 1));
	assign last_pixel = last_col && (y == Y_W'(V_PIXELS - 1));

	// ==========================================================================
	// Raster FSM
	// ==========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= INIT;
			start_q <= 1'b0;
		end else begin
			case (state)
				INIT: begin
					// First pixel goes out in SCAN
					state   <= SCAN;
					start_q <= 1'b1;
				end
				SCAN: begin
					// Next start right after each result
					start_q <= esc.done && !last_pixel;
					if (esc.done && last_pixel)
						state <= DRAIN;
				end
				DRAIN: begin
					// Mapper writes the last pixel here
					start_q <= 1'b0;
					state   <= DONE;
				end
				DONE: begin
					start_q <= 1'b0;
					state   <= DONE;
				end
				default: begin
					start_q <= 1'b0;
					state   <= INIT;
				end
			endcase
		end
	end

	// ==========================================================================
	// Coordinate stepping
	// ==========================================================================

	// Loaded in INIT and stepped on each result
	always_ff @(posedge clk) begin
		if (state == INIT) begin
			x     <= '0;
			y     <= '0;
			addr  <= '0;
			c_re  <= re_min;
			c_im  <= im_max;
			max_q <= max_iter;
		end else if (state == SCAN && esc.done) begin
			// y * H_PIXELS + x in raster order
			addr <= addr + 1'b1;
			if (last_col) begin
				// Row wrap
				x    <= '0;
				y    <= y + 1'b1;
				c_re <= re_min;
				c_im <= c_im - im_step;
			end else begin
				x    <= x + 1'b1;
				c_re <= c_re + re_step;
			end
		end
	end

	assign esc.start    = start_q;
	assign esc.c_re     = c_re;
	assign esc.c_im     = c_im;
	assign esc.max_iter = max_q;

	// Valid on the done cycle
	assign pix_addr   = addr;
	assign frame_done = (state == DONE);

	// Engine takes one pixel at a time
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		esc.start |-> !esc.busy);

endmodule

// ==== hw/color_mapper.sv ====
`include "mandel_params.svh"

module color_mapper import render_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	escape_if.mapper   esc,
	input  pix_addr_t  pix_addr,
	output logic       fb_we,
	output pix_addr_t  fb_addr,
	output rgb332_t    fb_color
);

	rgb332_t color;

	// ==========================================================================
	// Threshold ladder
	// ==========================================================================
	// Walk from the coarsest threshold down
	// so the smallest matching shift wins
	always_comb begin
		color = PALETTE[`MANDEL_PALETTE_N-1];
		if (esc.count == esc.max_iter) begin
			// Never escaped
			color = PALETTE[0];
		end else begin
			for (int k = `MANDEL_PALETTE_N - 2; k >= 1; k--) begin
				if (esc.count >= (esc.max_iter >> k))
					color = PALETTE[k];
			end
		end
	end

	// ==========================================================================
	// Framebuffer write
	// ==========================================================================

	// Strobe follows done by one cycle
	always_ff @(posedge clk) begin
		if (reset)
			fb_we <= 1'b0;
		else
			fb_we <= esc.done;
	end

	// Address and colour held between writes
	always_ff @(posedge clk) begin
		if (esc.done) begin
			fb_addr  <= pix_addr;
			fb_color <= color;
		end
	end

	// Engine needs at least one cycle per pixel
	a_we_gap: assert property (@(posedge clk) disable iff (reset)
		fb_we |=> !fb_we);

endmodule

// ==== hw/escape_engine.sv ====
`include "mandel_params.svh"

module escape_engine import fixed_point_pkg::*, render_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	escape_if.engine  esc
);

	// ==========================================================================
	// Iteration state
	// ==========================================================================

	logic  busy_q;
	iter_t count_q;

	// Current z
	fix_t  zr;
	fix_t  zi;

	// c captured on start
	fix_t  c_re_q;
	fix_t  c_im_q;

	// Products of this cycle
	fix_t  zr_sq;
	fix_t  zi_sq;
	fix_t  zr_zi;

	// |z|^2 with guard bits
	fix_mag_t mag;

	logic  hit_max;
	logic  escaped;
	logic  finish;

	// ==========================================================================
	// Datapath
	// ==========================================================================

	assign zr_sq = fix_mul(zr, zr);
	assign zi_sq = fix_mul(zi, zi);
	assign zr_zi = fix_mul(zr, zi);

	// Sign-extend before the add so it cannot wrap
	assign mag = fix_mag_t'(zr_sq) + fix_mag_t'(zi_sq);

	assign hit_max = (count_q == esc.max_iter);
	assign escaped = (mag > fix_mag_t'(`MANDEL_ESCAPE));

	// Exit test comes before the update
	assign finish = busy_q && (hit_max || escaped);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q  <= 1'b0;
			count_q <= '0;
		end else if (esc.start) begin
			busy_q  <= 1'b1;
			count_q <= '0;
		end else if (finish) begin
			// Result leaves this cycle
			busy_q  <= 1'b0;
		end else if (busy_q) begin
			count_q <= count_q + 1'b1;
		end
	end

	// z iteration and captured c
	always_ff @(posedge clk) begin
		if (esc.start) begin
			zr     <= '0;
			zi     <= '0;
			c_re_q <= esc.c_re;
			c_im_q <= esc.c_im;
		end else if (busy_q && !finish) begin
			// z <- z^2 + c
			zr <= zr_sq - zi_sq + c_re_q;
			zi <= (zr_zi <<< 1) + c_im_q;
		end
	end

	assign esc.busy  = busy_q;
	assign esc.done  = finish;
	assign esc.count = count_q;

	// ==========================================================================
	// Assertions
	// ==========================================================================

	// Counter stops at the scanner's limit
	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		esc.busy |-> (esc.count <= esc.max_iter));

	// Single-cycle result strobe
	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		esc.done |=> !esc.done);

	// Result only for a pixel taken in an earlier cycle
	a_done_busy: assert property (@(posedge clk) disable iff (reset)
		esc.done |-> $past(esc.start || esc.busy));

endmodule

// ==== hw/escape_if.sv ====
interface escape_if import fixed_point_pkg::*, render_pkg::*; ();

	// Scanner to engine
	logic  start;
	fix_t  c_re;
	fix_t  c_im;
	iter_t max_iter;

	// Engine back to scanner and mapper
	logic  busy;
	logic  done;
	iter_t count;

	// Issues one pixel at a time
	modport scanner (output start, c_re, c_im, max_iter, input busy, done);

	// Runs the z iteration
	modport engine (input start, c_re, c_im, max_iter, output busy, done, count);

	// Only looks at results
	modport mapper (input done, count, max_iter);

endinterface

// ==== hw/render_pkg.sv ====
`include "mandel_params.svh"

package render_pkg;

	// Raster walk
	typedef enum logic [1:0] {
		INIT,
		SCAN,
		DRAIN,
		DONE
	} scan_state_t;

	// Iteration count
	typedef logic [`MANDEL_ITER_W-1:0] iter_t;

	// Linear framebuffer address
	typedef logic [`MANDEL_ADDR_W-1:0] pix_addr_t;

	// RRR_GGG_BB pixel
	typedef logic [7:0] rgb332_t;

	// ==========================================================================
	// Colour ladder
	// ==========================================================================
	// Index 0 is inside the set
	// Index k for count >= max_iter >> k
	// Last entry catches the fastest escapes
	localparam rgb332_t PALETTE [`MANDEL_PALETTE_N] = '{
		8'b000_000_00,
		8'b011_001_00,
		8'b011_001_00,
		8'b101_010_01,
		8'b011_001_01,
		8'b001_001_01,
		8'b011_010_10,
		8'b010_100_10,
		8'b010_100_10,
		8'b010_100_10
	};

endpackage

// ==== hw/fixed_point_pkg.sv ====
`include "mandel_params.svh"

package fixed_point_pkg;

	// Signed 4.23 value
	typedef logic signed [`MANDEL_FIX_W-1:0] fix_t;

	// Two guard bits for zr^2 + zi^2
	typedef logic signed [`MANDEL_FIX_W+1:0] fix_mag_t;

	// Truncating 4.23 multiply
	// Full product is 8.46 so keep the sign and drop the top integer bits
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [2*`MANDEL_FIX_W-1:0] prod;
		prod = a * b;
		return {prod[2*`MANDEL_FIX_W-1],
			prod[`MANDEL_FRAC_W+`MANDEL_FIX_W-2:`MANDEL_FRAC_W]};
	endfunction

endpackage

// ==== include/mandel_params.svh ====
`ifndef MANDEL_PARAMS_SVH
`define MANDEL_PARAMS_SVH

// ==========================================================================
// Fixed-point format
// ==========================================================================

// Signed 4.23 word
`define MANDEL_FIX_W 27

// Fraction bits of the 4.23 word
`define MANDEL_FRAC_W 23

// ==========================================================================
// Counts and addresses
// ==========================================================================

// Iteration counter width
`define MANDEL_ITER_W 16

// Enough for a 640x480 framebuffer
`define MANDEL_ADDR_W 19

// Default raster size
`define MANDEL_H_DEFAULT 640
`define MANDEL_V_DEFAULT 480

// Escape bound on |z|^2 in 4.23 (4 << 23)
`define MANDEL_ESCAPE 33554432

// Entries in the colour ladder
`define MANDEL_PALETTE_N 10

`endif
